/* Makefile */
TOP = token_robot_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* project.f */
verilog/robot_pkg.sv
verilog/servo_cmd_if.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/command_fsm.sv
verilog/servo_bank.sv
verilog/token_robot_top.sv
verification/token_robot_tb.sv

/* verification/token_robot_tb.sv */
// token robot controller testbench
module token_robot_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int bit_clks    = 8;
	localparam int frame_clks  = 2000;
	localparam int max_entries = 16;

	logic       clk50m = 1'b0;
	logic       reset;
	logic       serial_raw;
	logic       serial_return;
	logic       tx_busy;
	logic [4:0] pwm;

	int         errors = 0;
	int         seed = 69;
	logic [7:0] rx_q [$];
	logic [7:0] mon_byte;
	string      cur_test = "reset_init";

	// command table
	int         n_entries;
	string      names [max_entries];
	logic [7:0] cmd [max_entries][4];
	int         rcount [max_entries];
	logic [7:0] rexp [max_entries][2];
	// -1 no pwm check, 0 to 4 high time on that channel, 5 all channels low
	int         pwm_chk [max_entries];
	int         width_exp [max_entries];

	token_robot_top #(
		.clks_per_bit(bit_clks),
		.servo_period(frame_clks),
		.pulse_min   (100),
		.pulse_step  (4)
	) i_token_robot_top (
		.clk50m       (clk50m),
		.reset        (reset),
		.serial_raw   (serial_raw),
		.serial_return(serial_return),
		.tx_busy      (tx_busy),
		.pwm          (pwm)
	);

	always #10 clk50m = ~clk50m;

	// reply decoder sampling mid-bit on falling edges
	always begin
		@(negedge clk50m);
		if (serial_return === 1'b0) begin
			repeat (bit_clks / 2) @(negedge clk50m);
			// transmitter flags busy for the whole frame
			if (tx_busy !== 1'b1) begin
				$display("MISMATCH %s tx_busy expected 1 actual %b", cur_test, tx_busy);
				errors++;
			end
			repeat (8) begin
				repeat (bit_clks) @(negedge clk50m);
				mon_byte = {serial_return, mon_byte[7:1]};
			end
			repeat (bit_clks) @(negedge clk50m);
			if (serial_return !== 1'b1) begin
				$display("stop bit missing on serial_return");
				errors++;
			end
			rx_q.push_back(mon_byte);
		end
	end

	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		repeat (10) begin
			@(posedge clk50m);
			serial_raw <= frame[0];
			frame = frame >> 1;
			repeat (bit_clks - 1) @(posedge clk50m);
		end
	endtask

	task automatic add_entry(input string name, input logic [7:0] b0, input logic [7:0] b1,
		input logic [7:0] b2, input logic [7:0] b3, input int cnt, input logic [7:0] r0,
		input logic [7:0] r1, input int ch, input int w);
		names[n_entries]     = name;
		cmd[n_entries][0]    = b0;
		cmd[n_entries][1]    = b1;
		cmd[n_entries][2]    = b2;
		cmd[n_entries][3]    = b3;
		rcount[n_entries]    = cnt;
		rexp[n_entries][0]   = r0;
		rexp[n_entries][1]   = r1;
		pwm_chk[n_entries]   = ch;
		width_exp[n_entries] = w;
		n_entries++;
	endtask

	task automatic build_table();
		int p;
		int w3;
		n_entries = 0;
		w3 = 0;
		add_entry("ping", robot_pkg::VERB_PING, 8'd0, 8'd0, 8'd0,
			1, robot_pkg::REPLY_PONG, 8'd0, -1, 0);
		for (int s = 1; s <= 5; s++) begin
			p = $random(seed) & 255;
			// four extra cycles per position step
			add_entry($sformatf("mtne_servo%0d", s), robot_pkg::VERB_MTNE, 8'(s), 8'(p), 8'd0,
				2, robot_pkg::REPLY_ACK, robot_pkg::VERB_MTNE, s - 1, 100 + 4 * p);
			if (s == 3) w3 = 100 + 4 * p;
		end
		add_entry("verb_zero", 8'd0, 8'd1, 8'd2, 8'd3, 0, 8'd0, 8'd0, -1, 0);
		add_entry("unknown_verb", 8'h7e, 8'd0, 8'd0, 8'd0, 0, 8'd0, 8'd0, -1, 0);
		add_entry("ping_after_ignore", robot_pkg::VERB_PING, 8'd0, 8'd0, 8'd0,
			1, robot_pkg::REPLY_PONG, 8'd0, -1, 0);
		// servo 3 keeps its pulse across a restart
		add_entry("restart", robot_pkg::VERB_RESTART, 8'd0, 8'd0, 8'd0,
			1, robot_pkg::REPLY_INIT, 8'd0, 2, w3);
		add_entry("mtne_clear", robot_pkg::VERB_MTNE, robot_pkg::MTNE_CLEAR, 8'd0, 8'd0,
			2, robot_pkg::REPLY_ACK, robot_pkg::VERB_MTNE, 5, 0);
	endtask

	task automatic check_replies(input string name, input int cnt, input logic [7:0] r0,
		input logic [7:0] r1);
		int t;
		logic [7:0] exp_b;
		t = 0;
		while (rx_q.size() < cnt && t < 60 * bit_clks) begin
			@(negedge clk50m);
			t++;
		end
		if (rx_q.size() < cnt) begin
			$display("%s: timeout waiting for reply bytes", name);
			errors++;
		end
		// quiet window to catch extra replies
		repeat (40 * bit_clks) @(negedge clk50m);
		if (rx_q.size() != cnt) begin
			$display("MISMATCH %s reply count expected %0d actual %0d", name, cnt, rx_q.size());
			errors++;
		end
		// line has been quiet for a while so the transmitter is idle
		if (tx_busy !== 1'b0) begin
			$display("MISMATCH %s tx_busy expected 0 actual %b", name, tx_busy);
			errors++;
		end
		for (int i = 0; i < cnt && i < rx_q.size(); i++) begin
			exp_b = (i == 0) ? r0 : r1;
			if (rx_q[i] !== exp_b) begin
				$display("MISMATCH %s reply %0d expected %02h actual %02h",
					name, i, exp_b, rx_q[i]);
				errors++;
			end
		end
	endtask

	task automatic measure_width(input logic [2:0] ch, output int width);
		int t;
		width = 0;
		t = 0;
		while (pwm[ch] !== 1'b0 && t < 3 * frame_clks) begin
			@(negedge clk50m);
			t++;
		end
		if (t >= 3 * frame_clks) begin
			$display("timeout waiting for pwm channel %0d to go low", ch);
			errors++;
		end
		t = 0;
		while (pwm[ch] !== 1'b1 && t < 3 * frame_clks) begin
			@(negedge clk50m);
			t++;
		end
		if (t >= 3 * frame_clks) begin
			$display("timeout waiting for a pulse on pwm channel %0d", ch);
			errors++;
		end
		while (pwm[ch] === 1'b1 && width < frame_clks) begin
			@(negedge clk50m);
			width++;
		end
	endtask

	task automatic check_pwm_low(input string name, input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk50m);
			if (pwm !== 5'b0) begin
				$display("MISMATCH %s pwm expected %05b actual %05b", name, 5'b0, pwm);
				errors++;
				break;
			end
		end
	endtask

	initial begin
		int w;
		reset = 1'b0;
		serial_raw = 1'b1;
		build_table();
		repeat (16) @(posedge clk50m);
		reset <= 1'b1;
		check_replies("reset_init", 1, robot_pkg::REPLY_INIT, 8'd0);
		check_pwm_low("reset_init", 2 * frame_clks);
		for (int k = 0; k < n_entries; k++) begin
			rx_q.delete();
			cur_test = names[k];
			for (int j = 0; j < 4; j++) begin
				send_byte(cmd[k][j]);
			end
			check_replies(names[k], rcount[k], rexp[k][0], rexp[k][1]);
			if (pwm_chk[k] == 5) begin
				// frame in flight may still carry the old pulse
				repeat (frame_clks + 20) @(negedge clk50m);
				check_pwm_low(names[k], frame_clks);
			end else if (pwm_chk[k] >= 0) begin
				repeat (2) begin
					measure_width(3'(pwm_chk[k]), w);
					if (w != width_exp[k]) begin
						$display("MISMATCH %s high time expected %0d actual %0d",
							names[k], width_exp[k], w);
						errors++;
					end
				end
			end
		end
		$display("token robot run complete, error count %0d", errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* verilog/command_fsm.sv */
// command controller state machine
module command_fsm (
	input  logic             clk50m,
	input  logic             reset,
	input  logic             rx_valid,
	input  robot_pkg::byte_t rx_data,
	input  logic             tx_busy,
	output logic             tx_start,
	output robot_pkg::byte_t tx_data,
	servo_cmd_if.master      servo
);

	robot_pkg::fsm_state_t state;
	robot_pkg::verb_t      verb;
	robot_pkg::byte_t      arg1;
	robot_pkg::byte_t      arg2;
	robot_pkg::reply_t     first_reply;
	logic                  echo_pending;
	logic                  tx_idle;

	// busy only rises the cycle after start
	assign tx_idle = !tx_busy && !tx_start;

	always_ff @(posedge clk50m or negedge reset) begin
		if (!reset) begin
			state           <= robot_pkg::s_announce;
			tx_start        <= 1'b0;
			echo_pending    <= 1'b0;
			servo.write     <= 1'b0;
			servo.clear_all <= 1'b0;
		end else begin
			tx_start        <= 1'b0;
			servo.write     <= 1'b0;
			servo.clear_all <= 1'b0;
			case (state)
				robot_pkg::s_announce: begin
					echo_pending <= 1'b0;
					if (tx_idle) begin
						tx_start <= 1'b1;
						state    <= robot_pkg::s_wait_tx;
					end
				end
				robot_pkg::s_verb: if (rx_valid) state <= robot_pkg::s_arg1;
				robot_pkg::s_arg1: if (rx_valid) state <= robot_pkg::s_arg2;
				robot_pkg::s_arg2: if (rx_valid) state <= robot_pkg::s_arg3;
				// fourth byte closes the frame, nothing in it is kept
				robot_pkg::s_arg3: if (rx_valid) state <= robot_pkg::s_decode;
				robot_pkg::s_decode: begin
					case (verb)
						robot_pkg::VERB_RESTART: state <= robot_pkg::s_announce;
						robot_pkg::VERB_PING: begin
							echo_pending <= 1'b0;
							state        <= robot_pkg::s_reply1;
						end
						robot_pkg::VERB_MTNE: begin
							echo_pending <= 1'b1;
							case (arg1)
								robot_pkg::MTNE_CLEAR: begin
									servo.clear_all <= 1'b1;
									state           <= robot_pkg::s_reply1;
								end
								robot_pkg::MTNE_SERVO1, robot_pkg::MTNE_SERVO2,
								robot_pkg::MTNE_SERVO3, robot_pkg::MTNE_SERVO4,
								robot_pkg::MTNE_SERVO5: begin
									servo.write <= 1'b1;
									state       <= robot_pkg::s_reply1;
								end
								default: state <= robot_pkg::s_announce;
							endcase
						end
						// verb 0 and unknown verbs get no reply
						default: state <= robot_pkg::s_verb;
					endcase
				end
				robot_pkg::s_reply1, robot_pkg::s_reply2: begin
					if (!tx_busy) begin
						tx_start <= 1'b1;
						state    <= robot_pkg::s_wait_tx;
						if (state == robot_pkg::s_reply2) echo_pending <= 1'b0;
					end
				end
				robot_pkg::s_wait_tx: begin
					if (tx_idle) begin
						state <= echo_pending ? robot_pkg::s_reply2 : robot_pkg::s_verb;
					end
				end
				default: state <= robot_pkg::s_announce;
			endcase
		end
	end

	// command bytes, reply bytes and servo payload
	always_ff @(posedge clk50m) begin
		if (rx_valid && state == robot_pkg::s_verb) verb <= rx_data;
		if (rx_valid && state == robot_pkg::s_arg1) arg1 <= rx_data;
		if (rx_valid && state == robot_pkg::s_arg2) arg2 <= rx_data;
		if (state == robot_pkg::s_decode) begin
			first_reply    <= (verb == robot_pkg::VERB_PING) ?
				robot_pkg::REPLY_PONG : robot_pkg::REPLY_ACK;
			servo.index    <= robot_pkg::servo_idx_t'(arg1 - robot_pkg::MTNE_SERVO1);
			servo.position <= arg2;
		end
		case (state)
			robot_pkg::s_announce: tx_data <= robot_pkg::REPLY_INIT;
			robot_pkg::s_reply1:   tx_data <= first_reply;
			// echo of the verb
			robot_pkg::s_reply2:   tx_data <= verb;
			default:               tx_data <= tx_data;
		endcase
	end

	a_state_legal: assert property (@(posedge clk50m) disable iff (!reset)
		state inside {robot_pkg::s_announce, robot_pkg::s_verb, robot_pkg::s_arg1,
			robot_pkg::s_arg2, robot_pkg::s_arg3, robot_pkg::s_decode,
			robot_pkg::s_reply1, robot_pkg::s_wait_tx, robot_pkg::s_reply2});

endmodule

/* verilog/robot_pkg.sv */
// token robot shared types
package robot_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [7:0] verb_t;
	typedef logic [7:0] reply_t;
	typedef logic [7:0] servo_pos_t;
	typedef logic [2:0] servo_idx_t;

	// controller states, announce first after reset
	typedef enum logic [3:0] {
		s_announce,
		s_verb,
		s_arg1,
		s_arg2,
		s_arg3,
		s_decode,
		s_reply1,
		s_wait_tx,
		s_reply2
	} fsm_state_t;

	localparam verb_t VERB_RESTART = 8'd1;
	localparam verb_t VERB_PING    = 8'd2;
	localparam verb_t VERB_MTNE    = 8'd3;

	localparam reply_t REPLY_INIT = 8'd1;
	localparam reply_t REPLY_ACK  = 8'd4;
	localparam reply_t REPLY_PONG = 8'd5;

	// maintenance sub-codes, sent in arg1
	localparam byte_t MTNE_CLEAR  = 8'd0;
	localparam byte_t MTNE_SERVO1 = 8'd1;
	localparam byte_t MTNE_SERVO2 = 8'd2;
	localparam byte_t MTNE_SERVO3 = 8'd3;
	localparam byte_t MTNE_SERVO4 = 8'd4;
	localparam byte_t MTNE_SERVO5 = 8'd5;

	localparam int NUM_SERVOS = 5;

endpackage

/* verilog/servo_bank.sv */
// servo pulse generator bank
module servo_bank #(
	parameter int servo_period = 1000000,
	parameter int pulse_min    = 50000,
	parameter int pulse_step   = 196
) (
	input  logic                              clk50m,
	input  logic                              reset,
	servo_cmd_if.slave                        servo,
	output logic [robot_pkg::NUM_SERVOS-1:0] pwm
);

	localparam int cnt_w = $clog2(servo_period);

	logic [cnt_w-1:0]                 frame_cnt;
	logic                             frame_end;
	logic [robot_pkg::NUM_SERVOS-1:0] en;
	// copies taken at frame start
	logic [robot_pkg::NUM_SERVOS-1:0] en_act;
	logic [cnt_w-1:0]                 width [robot_pkg::NUM_SERVOS];
	robot_pkg::servo_pos_t            pos [robot_pkg::NUM_SERVOS];

	assign frame_end = (frame_cnt == cnt_w'(servo_period - 1));

	always_ff @(posedge clk50m or negedge reset) begin
		if (!reset) begin
			frame_cnt <= '0;
			en        <= '0;
			en_act    <= '0;
			pwm       <= '0;
		end else begin
			frame_cnt <= frame_end ? '0 : frame_cnt + 1'b1;
			if (servo.clear_all) begin
				en <= '0;
			end else if (servo.write) begin
				en[servo.index] <= 1'b1;
			end
			if (frame_end) en_act <= en;
			// high for width cycles at the head of each frame
			for (int i = 0; i < robot_pkg::NUM_SERVOS; i++) begin
				pwm[i] <= en_act[i] && (frame_cnt < width[i]);
			end
		end
	end

	always_ff @(posedge clk50m) begin
		if (servo.write) pos[servo.index] <= servo.position;
		if (frame_end) begin
			for (int i = 0; i < robot_pkg::NUM_SERVOS; i++) begin
				width[i] <= cnt_w'(pulse_min + int'(pos[i]) * pulse_step);
			end
		end
	end

	// sub-code decode in the controller only produces channels 0 to 4
	a_index_range: assert property (@(posedge clk50m) disable iff (!reset)
		servo.write |-> (int'(servo.index) < robot_pkg::NUM_SERVOS));

endmodule

/* verilog/servo_cmd_if.sv */
// maintenance servo command link
interface servo_cmd_if;

	// one-cycle strobes
	logic write;
	logic clear_all;
	// valid with write
	robot_pkg::servo_idx_t index;
	robot_pkg::servo_pos_t position;

	modport master (
		output write,
		output clear_all,
		output index,
		output position
	);

	modport slave (
		input write,
		input clear_all,
		input index,
		input position
	);

endinterface

/* verilog/token_robot_top.sv */
// token robot controller top
module token_robot_top #(
	parameter int clks_per_bit = 434,
	parameter int servo_period = 1000000,
	parameter int pulse_min    = 50000,
	parameter int pulse_step   = 196
) (
	input  logic                              clk50m,
	input  logic                              reset,
	input  logic                              serial_raw,
	output logic                              serial_return,
	output logic                              tx_busy,
	output logic [robot_pkg::NUM_SERVOS-1:0] pwm
);

	logic             rx_valid;
	robot_pkg::byte_t rx_data;
	logic             tx_start;
	robot_pkg::byte_t tx_data;

	servo_cmd_if servo_cmd ();

	uart_rx #(.clks_per_bit(clks_per_bit)) i_uart_rx (
		.clk50m    (clk50m),
		.reset     (reset),
		.serial_raw(serial_raw),
		.rx_valid  (rx_valid),
		.rx_data   (rx_data)
	);

	uart_tx #(.clks_per_bit(clks_per_bit)) i_uart_tx (
		.clk50m       (clk50m),
		.reset        (reset),
		.tx_start     (tx_start),
		.tx_data      (tx_data),
		.serial_return(serial_return),
		.tx_busy      (tx_busy)
	);

	command_fsm i_command_fsm (
		.clk50m  (clk50m),
		.reset   (reset),
		.rx_valid(rx_valid),
		.rx_data (rx_data),
		.tx_busy (tx_busy),
		.tx_start(tx_start),
		.tx_data (tx_data),
		.servo   (servo_cmd.master)
	);

	servo_bank #(
		.servo_period(servo_period),
		.pulse_min   (pulse_min),
		.pulse_step  (pulse_step)
	) i_servo_bank (
		.clk50m(clk50m),
		.reset (reset),
		.servo (servo_cmd.slave),
		.pwm   (pwm)
	);

endmodule

/* verilog/uart_rx.sv */
// serial byte receiver
module uart_rx #(
	parameter int clks_per_bit = 434
) (
	input  logic            clk50m,
	input  logic            reset,
	input  logic            serial_raw,
	output logic            rx_valid,
	output robot_pkg::byte_t rx_data
);

	localparam int cnt_w = $clog2(clks_per_bit);
	// half a bit to reach mid start bit, less the two sync flops
	localparam int start_load = clks_per_bit / 2 + 2;

	logic             sync1;
	logic             sync2;
	logic             active;
	logic             bit_tick;
	logic [cnt_w-1:0] clk_cnt;
	logic [3:0]       bit_cnt;

	assign bit_tick = (clk_cnt == cnt_w'(clks_per_bit - 1));

	always_ff @(posedge clk50m or negedge reset) begin
		if (!reset) begin
			sync1    <= 1'b1;
			sync2    <= 1'b1;
			active   <= 1'b0;
			rx_valid <= 1'b0;
			clk_cnt  <= '0;
			bit_cnt  <= '0;
		end else begin
			sync1    <= serial_raw;
			sync2    <= sync1;
			rx_valid <= 1'b0;
			if (!active) begin
				if (!sync2) begin
					active  <= 1'b1;
					clk_cnt <= cnt_w'(start_load);
					bit_cnt <= '0;
				end
			end else if (bit_tick) begin
				clk_cnt <= '0;
				if (bit_cnt == 4'd0 && sync2) begin
					// glitch, line went back high before mid start bit
					active <= 1'b0;
				end else if (bit_cnt == 4'd9) begin
					active   <= 1'b0;
					rx_valid <= sync2;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

	// data bits arrive lsb first
	always_ff @(posedge clk50m) begin
		if (active && bit_tick && bit_cnt >= 4'd1 && bit_cnt <= 4'd8) begin
			rx_data <= {sync2, rx_data[7:1]};
		end
	end

endmodule

/* verilog/uart_tx.sv */
// serial byte transmitter
module uart_tx #(
	parameter int clks_per_bit = 434
) (
	input  logic            clk50m,
	input  logic            reset,
	input  logic            tx_start,
	input  robot_pkg::byte_t tx_data,
	output logic            serial_return,
	output logic            tx_busy
);

	localparam int cnt_w = $clog2(clks_per_bit);

	logic             bit_tick;
	logic [cnt_w-1:0] clk_cnt;
	logic [3:0]       bit_cnt;
	// data bits then the stop bit
	logic [8:0]       shreg;

	assign bit_tick = (clk_cnt == cnt_w'(clks_per_bit - 1));

	always_ff @(posedge clk50m or negedge reset) begin
		if (!reset) begin
			serial_return <= 1'b1;
			tx_busy       <= 1'b0;
			clk_cnt       <= '0;
			bit_cnt       <= '0;
		end else if (!tx_busy) begin
			if (tx_start) begin
				// start bit goes out straight away
				serial_return <= 1'b0;
				tx_busy       <= 1'b1;
				clk_cnt       <= '0;
				bit_cnt       <= '0;
			end
		end else if (bit_tick) begin
			clk_cnt <= '0;
			if (bit_cnt == 4'd9) begin
				tx_busy <= 1'b0;
			end else begin
				serial_return <= shreg[0];
				bit_cnt       <= bit_cnt + 4'd1;
			end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk50m) begin
		if (!tx_busy && tx_start) begin
			shreg <= {1'b1, tx_data};
		end else if (tx_busy && bit_tick) begin
			shreg <= {1'b1, shreg[8:1]};
		end
	end

	// controller must hold off while a frame is going out
	a_no_start_busy: assert property (@(posedge clk50m) disable iff (!reset)
		tx_start |-> !tx_busy);

endmodule
